//--- lsq_defines.svh
`ifndef LSQ_DEFINES_SVH
`define LSQ_DEFINES_SVH

// Queue sizing
`define LSQ_DEPTH 8

// Index width into the queue, pointers carry one extra wrap bit
`define LSQ_IDX_W ($clog2(`LSQ_DEPTH))

// Instruction slots offered by dispatch each cycle
`define DISPATCH_WIDTH 2

// Data memory words, selected by address bits 5:2
`define MEM_WORDS 16

`endif

//--- lsq_pkg.sv
package lsq_pkg;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_e;

    typedef struct packed {
        logic [11:0] imm;      // imm[11:0]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]  imm_hi;   // imm[11:5]
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;   // imm[4:0]
        logic [6:0]  opcode;
    } s_type_t;

    // Same 32-bit word, I-type and S-type field layouts
    typedef union packed {
        i_type_t i;
        s_type_t s;
    } inst_word_u;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [4:0]  rd;
        logic [31:0] base;       // rs1 value
        logic [31:0] imm;        // Sign-extended offset
        logic [31:0] data;       // rs2 value for stores
        logic        addr_ready;
        logic [31:0] addr;
    } lsq_entry_t;

endpackage

//--- lsq_if.sv
`timescale 1ns/10ps
`include "lsq_defines.svh"

interface lsq_if;
    import lsq_pkg::*;

    logic [`LSQ_DEPTH-1:0]   pend_mask;  // Valid entries still waiting on an address
    logic [`LSQ_IDX_W-1:0]   tail_idx;   // Oldest entry
    lsq_entry_t              rd_entry;
    logic [`LSQ_IDX_W-1:0]   rd_idx;
    logic                    upd_en;
    logic [`LSQ_IDX_W-1:0]   upd_idx;
    logic [31:0]             upd_addr;

    modport queue (
        output pend_mask,
        output tail_idx,
        output rd_entry,
        input  rd_idx,
        input  upd_en,
        input  upd_idx,
        input  upd_addr
    );

    modport agen (
        input  pend_mask,
        input  tail_idx,
        input  rd_entry,
        output rd_idx,
        output upd_en,
        output upd_idx,
        output upd_addr
    );

endinterface

//--- lsq_decode.sv
`timescale 1ns/10ps
`include "lsq_defines.svh"

module lsq_decode (
    input  logic [`DISPATCH_WIDTH-1:0]           disp_valid,
    input  logic [31:0]                          disp_inst [`DISPATCH_WIDTH],
    input  logic [31:0]                          disp_rs1_val [`DISPATCH_WIDTH],
    input  logic [31:0]                          disp_rs2_val [`DISPATCH_WIDTH],
    input  logic                                 full,
    output logic                                 push,
    output logic [$clog2(`DISPATCH_WIDTH+1)-1:0] push_amt,
    output lsq_pkg::lsq_entry_t                  push_entry [`DISPATCH_WIDTH]
);
    import lsq_pkg::*;

    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [2:0] F3_WORD  = 3'b010;    // LW and SW share funct3

    inst_word_u word [`DISPATCH_WIDTH];
    logic       is_load [`DISPATCH_WIDTH];
    logic       is_store [`DISPATCH_WIDTH];
    lsq_entry_t slot_entry [`DISPATCH_WIDTH];

    always_comb begin
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            word[s]     = disp_inst[s];
            is_load[s]  = (word[s].i.opcode == OP_LOAD) && (word[s].i.funct3 == F3_WORD);
            is_store[s] = (word[s].s.opcode == OP_STORE) && (word[s].s.funct3 == F3_WORD);

            slot_entry[s]            = '0;
            slot_entry[s].valid      = 1'b1;
            slot_entry[s].op         = is_store[s] ? MEM_STORE : MEM_LOAD;
            slot_entry[s].rd         = is_store[s] ? 5'd0 : word[s].i.rd;
            slot_entry[s].base       = disp_rs1_val[s];
            slot_entry[s].data       = disp_rs2_val[s];
            if (is_store[s])
                slot_entry[s].imm = {{20{word[s].s.imm_hi[6]}}, word[s].s.imm_hi,
                                     word[s].s.imm_lo};
            else
                slot_entry[s].imm = {{20{word[s].i.imm[11]}}, word[s].i.imm};
        end
    end

    // Compact surviving slots downward, slot 0 keeps priority
    always_comb begin
        int n;
        n = 0;
        for (int k = 0; k < `DISPATCH_WIDTH; k++)
            push_entry[k] = '0;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            if (disp_valid[s] && !full && (is_load[s] || is_store[s])) begin
                push_entry[n] = slot_entry[s];
                n = n + 1;
            end
        end
        push_amt = n[$clog2(`DISPATCH_WIDTH+1)-1:0];
    end

    assign push = (push_amt != '0);

endmodule

//--- ls_queue.sv
`timescale 1ns/10ps
`include "lsq_defines.svh"

module ls_queue (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 push,
    input  logic [$clog2(`DISPATCH_WIDTH+1)-1:0] push_amt,
    input  lsq_pkg::lsq_entry_t                  push_entry [`DISPATCH_WIDTH],
    input  logic                                 pop,
    lsq_if.queue                                 lsq,
    output lsq_pkg::lsq_entry_t                  head_entry,
    output logic                                 full,
    output logic                                 empty
);
    import lsq_pkg::*;

    // New entries go in at head_ptr, the oldest one sits at tail_ptr
    lsq_entry_t              entries [`LSQ_DEPTH];
    logic [`LSQ_IDX_W:0]     head_ptr;
    logic [`LSQ_IDX_W:0]     tail_ptr;
    logic [`LSQ_IDX_W-1:0]   head_idx;
    logic [`LSQ_IDX_W-1:0]   wr_idx [`DISPATCH_WIDTH];
    logic [`LSQ_IDX_W:0]     count;

    assign head_idx     = head_ptr[`LSQ_IDX_W-1:0];
    assign lsq.tail_idx = tail_ptr[`LSQ_IDX_W-1:0];

    always_comb begin
        for (int k = 0; k < `DISPATCH_WIDTH; k++)
            wr_idx[k] = head_idx + (`LSQ_IDX_W)'(k);  // Wraps at the depth
    end

    always_comb begin
        count = '0;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
            if (entries[i].valid)
                count = count + 1'b1;
        end
    end

    // Not enough room left for a full dispatch group
    assign full  = (count > (`LSQ_DEPTH - `DISPATCH_WIDTH));
    assign empty = (head_ptr == tail_ptr);

    always_comb begin
        for (int i = 0; i < `LSQ_DEPTH; i++)
            lsq.pend_mask[i] = entries[i].valid && !entries[i].addr_ready;
    end

    assign lsq.rd_entry = entries[lsq.rd_idx];
    assign head_entry   = entries[lsq.tail_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < `LSQ_DEPTH; i++)
                entries[i].valid <= 1'b0;
        end else begin
            if (push) begin
                for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
                    if (k < push_amt)
                        entries[wr_idx[k]] <= push_entry[k];
                end
                head_ptr <= head_ptr + (`LSQ_IDX_W+1)'(push_amt);
            end

            if (pop) begin
                entries[lsq.tail_idx].valid <= 1'b0;
                tail_ptr <= tail_ptr + 1'b1;
            end

            // Address fill from execute, never targets a slot being pushed
            if (lsq.upd_en) begin
                entries[lsq.upd_idx].addr       <= lsq.upd_addr;
                entries[lsq.upd_idx].addr_ready <= 1'b1;
            end
        end
    end

endmodule

//--- lsq_execute.sv
`timescale 1ns/10ps
`include "lsq_defines.svh"

module lsq_execute (
    input  logic clk,
    input  logic rst,
    lsq_if.agen  lsq
);
    import lsq_pkg::*;

    logic [`LSQ_IDX_W-1:0] rot_idx [`LSQ_DEPTH];
    logic [`LSQ_IDX_W-1:0] sel_idx;
    logic                  found;

    always_comb begin
        for (int k = 0; k < `LSQ_DEPTH; k++)
            rot_idx[k] = lsq.tail_idx + (`LSQ_IDX_W)'(k);   // Age order from oldest
    end

    // First pending entry walking up from the tail is the oldest one
    always_comb begin
        found   = 1'b0;
        sel_idx = lsq.tail_idx;
        for (int k = 0; k < `LSQ_DEPTH; k++) begin
            if (!found && lsq.pend_mask[rot_idx[k]]) begin
                found   = 1'b1;
                sel_idx = rot_idx[k];
            end
        end
    end

    assign lsq.rd_idx   = sel_idx;
    assign lsq.upd_idx  = sel_idx;
    assign lsq.upd_en   = found;
    assign lsq.upd_addr = lsq.rd_entry.base + lsq.rd_entry.imm;

endmodule

//--- lsq_result.sv
`timescale 1ns/10ps
`include "lsq_defines.svh"

module lsq_result (
    input  logic                clk,
    input  logic                rst,
    input  lsq_pkg::lsq_entry_t head_entry,
    output logic                pop,
    output logic                load_valid,
    output logic [4:0]          load_rd,
    output logic [31:0]         load_data
);
    import lsq_pkg::*;

    localparam int MEM_IDX_W = $clog2(`MEM_WORDS);

    logic [31:0]          mem [`MEM_WORDS];
    logic [MEM_IDX_W-1:0] word_idx;
    logic                 do_load;
    logic                 do_store;

    // Byte offset bits are dropped, word select only
    assign word_idx = head_entry.addr[MEM_IDX_W+1:2];

    assign pop      = head_entry.valid && head_entry.addr_ready;
    assign do_load  = pop && (head_entry.op == MEM_LOAD);
    assign do_store = pop && (head_entry.op == MEM_STORE);

    always_ff @(posedge clk) begin
        if (rst) begin
            load_valid <= 1'b0;
            for (int i = 0; i < `MEM_WORDS; i++)
                mem[i] <= '0;
        end else begin
            load_valid <= do_load;             // One cycle per retired load
            if (do_store)
                mem[word_idx] <= head_entry.data;
        end
    end

    // Load result payload
    always_ff @(posedge clk) begin
        if (do_load) begin
            load_rd   <= head_entry.rd;
            load_data <= mem[word_idx];
        end
    end

endmodule

//--- lsq_top.sv
`timescale 1ns/10ps
`include "lsq_defines.svh"

module lsq_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`DISPATCH_WIDTH-1:0] disp_valid,
    input  logic [31:0]                disp_inst [`DISPATCH_WIDTH],
    input  logic [31:0]                disp_rs1_val [`DISPATCH_WIDTH],
    input  logic [31:0]                disp_rs2_val [`DISPATCH_WIDTH],
    output logic                       full,
    output logic                       empty,
    output logic                       load_valid,
    output logic [4:0]                 load_rd,
    output logic [31:0]                load_data
);
    import lsq_pkg::*;

    logic                                 push;
    logic [$clog2(`DISPATCH_WIDTH+1)-1:0] push_amt;
    lsq_entry_t                           push_entry [`DISPATCH_WIDTH];
    logic                                 pop;
    lsq_entry_t                           head_entry;

    lsq_if lsq_bus ();  // Queue to address generation

    lsq_decode u_decode (
        .disp_valid   (disp_valid),
        .disp_inst    (disp_inst),
        .disp_rs1_val (disp_rs1_val),
        .disp_rs2_val (disp_rs2_val),
        .full         (full),
        .push         (push),
        .push_amt     (push_amt),
        .push_entry   (push_entry)
    );

    ls_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_amt   (push_amt),
        .push_entry (push_entry),
        .pop        (pop),
        .lsq        (lsq_bus.queue),
        .head_entry (head_entry),
        .full       (full),
        .empty      (empty)
    );

    lsq_execute u_execute (
        .clk (clk),
        .rst (rst),
        .lsq (lsq_bus.agen)
    );

    lsq_result u_result (
        .clk        (clk),
        .rst        (rst),
        .head_entry (head_entry),
        .pop        (pop),
        .load_valid (load_valid),
        .load_rd    (load_rd),
        .load_data  (load_data)
    );

endmodule

//--- tb_lsq.sv
`timescale 1ns/10ps
`include "lsq_defines.svh"

module tb_lsq;
    localparam int MAX_LINES  = 64;
    localparam int WAIT_LIMIT = 200;    // Cycles per wait loop

    logic                       clk;
    logic                       rst;
    logic [`DISPATCH_WIDTH-1:0] disp_valid;
    logic [31:0]                disp_inst [`DISPATCH_WIDTH];
    logic [31:0]                disp_rs1_val [`DISPATCH_WIDTH];
    logic [31:0]                disp_rs2_val [`DISPATCH_WIDTH];
    logic                       full;
    logic                       empty;
    logic                       load_valid;
    logic [4:0]                 load_rd;
    logic [31:0]                load_data;

    logic [`DISPATCH_WIDTH-1:0] vec_valid [MAX_LINES];    // Dispatch vectors
    logic [31:0]                vec_inst [MAX_LINES][`DISPATCH_WIDTH];
    logic [31:0]                vec_rs1 [MAX_LINES][`DISPATCH_WIDTH];
    logic [31:0]                vec_rs2 [MAX_LINES][`DISPATCH_WIDTH];
    int                         num_vec;
    string                      exp_name [$];             // Load results in program order
    logic [4:0]                 exp_rd [$];
    logic [31:0]                exp_data [$];
    int                         exp_idx;
    int                         errors;
    int                         checks;
    bit                         aborted;
    bit                         saw_full;                 // Dispatch had to hold a vector

    lsq_top dut (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_inst    (disp_inst),
        .disp_rs1_val (disp_rs1_val),
        .disp_rs2_val (disp_rs2_val),
        .full         (full),
        .empty        (empty),
        .load_valid   (load_valid),
        .load_rd      (load_rd),
        .load_data    (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic load_stim();
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        logic [31:0] f [8];
        fd = $fopen("lsq_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open lsq_stim.txt");
            aborted = 1'b1;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                kind = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s", kind);
                if (kind == "D" && num_vec < MAX_LINES) begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", kind,
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    vec_valid[num_vec] = {f[1][0], f[0][0]};
                    for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
                        vec_inst[num_vec][s] = f[2+s];
                        vec_rs1[num_vec][s]  = f[4+s];
                        vec_rs2[num_vec][s]  = f[6+s];
                    end
                    num_vec++;
                end else if (kind == "E") begin
                    n = $sscanf(line, "%s %s %h %h", kind, name, f[0], f[1]);
                    exp_name.push_back(name);
                    exp_rd.push_back(f[0][4:0]);
                    exp_data.push_back(f[1]);
                end
            end
            $fclose(fd);
        end
    endtask

    // Words stay on the bus until a cycle with full low takes them
    task automatic drive_vector(input int v);
        int waited;
        @(posedge clk);
        disp_valid <= vec_valid[v];
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            disp_inst[s]    <= vec_inst[v][s];
            disp_rs1_val[s] <= vec_rs1[v][s];
            disp_rs2_val[s] <= vec_rs2[v][s];
        end
        waited = 0;
        @(negedge clk);
        while (full && waited < WAIT_LIMIT) begin
            saw_full = 1'b1;
            @(negedge clk);
            waited++;
        end
        if (full) begin
            $display("Timed out waiting for full to drop at vector %0d", v);
            aborted = 1'b1;
        end
    endtask

    task automatic wait_empty();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!empty && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!empty) begin
            $display("Timed out waiting for the queue to drain");
            aborted = 1'b1;
        end
        @(negedge clk);                 // Last load result reaches the monitor
    endtask

    // Load results checked mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (!rst && load_valid) begin
            assert (exp_idx < exp_rd.size()) else begin
                $display("Load result rd=%0d data=%08h arrived with nothing expected",
                         load_rd, load_data);
                errors++;
            end
            if (exp_idx < exp_rd.size()) begin
                checks++;
                assert (load_rd == exp_rd[exp_idx] && load_data == exp_data[exp_idx])
                else begin
                    $display("[ERROR] %s expected rd=%0d data=%08h actual rd=%0d data=%08h",
                             exp_name[exp_idx], exp_rd[exp_idx], exp_data[exp_idx],
                             load_rd, load_data);
                    errors++;
                end
                exp_idx++;
            end
        end
    end

    initial begin
        rst        <= 1'b1;
        disp_valid <= '0;
        for (int s = 0; s < `DISPATCH_WIDTH; s++) begin
            disp_inst[s]    <= '0;
            disp_rs1_val[s] <= '0;
            disp_rs2_val[s] <= '0;
        end
        errors   = 0;
        checks   = 0;
        exp_idx  = 0;
        num_vec  = 0;
        aborted  = 1'b0;
        saw_full = 1'b0;
        load_stim();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checks++;
        assert (empty === 1'b1 && full === 1'b0) else begin
            $display("[ERROR] after_reset expected empty=1 full=0 actual empty=%0b full=%0b",
                     empty, full);
            errors++;
        end
        for (int v = 0; v < num_vec && !aborted; v++)
            drive_vector(v);
        @(posedge clk);
        disp_valid <= '0;
        if (!aborted)
            wait_empty();
        assert (aborted || exp_idx == exp_rd.size()) else begin
            $display("%0d expected load results never arrived", exp_rd.size() - exp_idx);
            errors++;
        end
        assert (aborted || saw_full) else begin
            $display("Queue never raised full during the back-pressure run");
            errors++;
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0 && !aborted && num_vec > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
lsq_pkg.sv
lsq_if.sv
lsq_decode.sv
ls_queue.sv
lsq_execute.sv
lsq_result.sv
lsq_top.sv
tb_lsq.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --assert --timing -Wno-fatal
TOP      = tb_lsq
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- lsq_stim.txt
# D v0 v1 inst0 inst1 rs1_0 rs1_1 rs2_0 rs2_1   (hex, one dispatch cycle)
# E name rd data   (hex, next load result in program order)
D 1 0 0020A423 00000000 00000100 00000000 DEADBEEF 00000000
D 1 0 0180A283 00000000 000000F0 00000000 00000000 00000000
E store_load 05 DEADBEEF
D 1 1 0020A623 0020A823 00000000 00000000 11112222 33334444
D 1 1 00C0A303 0100A383 00000000 00000000 00000000 00000000
E two_wide 06 11112222
E two_wide 07 33334444
D 1 1 00108093 0080A403 00000000 00000000 00000000 00000000
E filter_op 08 DEADBEEF
D 0 1 0000A503 00C0A483 00000000 00000000 00000000 00000000
E filter_valid 09 11112222
D 1 1 0020A023 0020A023 00000020 00000024 A0000008 A0000009
D 1 1 0020A023 0020A023 00000028 0000002C A000000A A000000B
D 1 1 0020A023 0020A023 00000030 00000034 A000000C A000000D
D 1 1 0020A023 0020A023 00000038 0000003C A000000E A000000F
D 1 1 0000A803 0020A023 00000020 00000020 00000000 B0000008
E backpressure 10 A0000008
D 1 1 0000A883 0000A903 00000020 0000003C 00000000 00000000
E backpressure 11 B0000008
E backpressure 12 A000000F
D 1 1 0000A983 0000AA03 00000024 00000038 00000000 00000000
E backpressure 13 A0000009
E backpressure 14 A000000E
D 1 1 0000AA83 0000AB03 0000002C 00000030 00000000 00000000
E backpressure 15 A000000B
E backpressure 16 A000000C
D 1 1 0000AB83 0000A803 00000034 00000028 00000000 00000000
E backpressure 17 A000000D
E backpressure 10 A000000A
D 1 1 FE20A023 FE20AE23 00000034 0000001C CAFEF00D 0BADCAFE
D 1 1 FF80A603 8000A683 0000001C 00000818 00000000 00000000
E imm_neg 0C CAFEF00D
E imm_neg 0D 0BADCAFE
D 1 1 00208E23 01C0A703 00000000 00000000 FFFFFFFF 00000000
E unwritten 0E 00000000
D 1 0 7FC0A783 00000000 00000808 00000000 00000000 00000000
E unwritten 0F 00000000
